// File: all.f
logic/io_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart.sv
logic/perf_counters.sv
logic/mmio_regs.sv
logic/io_top.sv
testbench/io_tb.sv

// File: logic/io_pkg.sv
`default_nettype none

package io_pkg;

    // *************************************************
    // Widths.
    // *************************************************
    localparam int data_w = 32;
    localparam int byte_w = 8;

    // *************************************************
    // UART bit timing.
    // *************************************************
    // Short bit time to keep simulation fast.
    localparam int clks_per_bit = 8;
    localparam int bit_cnt_w = $clog2(clks_per_bit);
    // Start bit, data bits and stop bit.
    localparam int frame_bits = byte_w + 2;
    localparam int bit_idx_w = $clog2(frame_bits);

    // *************************************************
    // Register map.
    // *************************************************
    localparam logic [data_w-1:0] addr_uart_ctrl   = 32'h8000_0000;
    localparam logic [data_w-1:0] addr_uart_rdata  = 32'h8000_0004;
    localparam logic [data_w-1:0] addr_uart_tdata  = 32'h8000_0008;
    localparam logic [data_w-1:0] addr_cycle_cnt   = 32'h8000_0010;
    localparam logic [data_w-1:0] addr_inst_cnt    = 32'h8000_0014;
    localparam logic [data_w-1:0] addr_rst_cnt     = 32'h8000_0018;
    localparam logic [data_w-1:0] addr_br_inst_cnt = 32'h8000_001C;
    localparam logic [data_w-1:0] addr_br_suc_cnt  = 32'h8000_0020;

endpackage

`default_nettype wire

// File: logic/io_top.sv
`timescale 1ns/10ps
`default_nettype none

module io_top import io_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [data_w-1:0] addr,
    input  logic [data_w-1:0] din,
    input  logic              io_en,
    input  logic              inst_retire,
    input  logic              br_inst,
    input  logic              br_suc,
    input  logic              serial_in,
    output logic              serial_out,
    output logic [data_w-1:0] dout
);

    logic [byte_w-1:0] tx_data;
    logic              tx_valid;
    logic              tx_ready;
    logic [byte_w-1:0] rx_data;
    logic              rx_valid;
    logic              rx_ready;

    logic              cnt_clear;
    logic [data_w-1:0] cycle_cnt;
    logic [data_w-1:0] inst_cnt;
    logic [data_w-1:0] br_inst_cnt;
    logic [data_w-1:0] br_suc_cnt;

    mmio_regs u_regs (
        .clk         (clk),
        .arst_n      (arst_n),
        .addr        (addr),
        .din         (din),
        .io_en       (io_en),
        .dout        (dout),
        .tx_data     (tx_data),
        .tx_valid    (tx_valid),
        .tx_ready    (tx_ready),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .rx_ready    (rx_ready),
        .cnt_clear   (cnt_clear),
        .cycle_cnt   (cycle_cnt),
        .inst_cnt    (inst_cnt),
        .br_inst_cnt (br_inst_cnt),
        .br_suc_cnt  (br_suc_cnt)
    );

    uart u_uart (
        .clk        (clk),
        .arst_n     (arst_n),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .serial_in  (serial_in),
        .serial_out (serial_out)
    );

    perf_counters u_cnt (
        .clk         (clk),
        .arst_n      (arst_n),
        .cnt_clear   (cnt_clear),
        .inst_retire (inst_retire),
        .br_inst     (br_inst),
        .br_suc      (br_suc),
        .cycle_cnt   (cycle_cnt),
        .inst_cnt    (inst_cnt),
        .br_inst_cnt (br_inst_cnt),
        .br_suc_cnt  (br_suc_cnt)
    );

endmodule

`default_nettype wire

// File: logic/mmio_regs.sv
`timescale 1ns/10ps
`default_nettype none

module mmio_regs import io_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [data_w-1:0] addr,
    input  logic [data_w-1:0] din,
    input  logic              io_en,
    output logic [data_w-1:0] dout,
    output logic [byte_w-1:0] tx_data,
    output logic              tx_valid,
    input  logic              tx_ready,
    input  logic [byte_w-1:0] rx_data,
    input  logic              rx_valid,
    output logic              rx_ready,
    output logic              cnt_clear,
    input  logic [data_w-1:0] cycle_cnt,
    input  logic [data_w-1:0] inst_cnt,
    input  logic [data_w-1:0] br_inst_cnt,
    input  logic [data_w-1:0] br_suc_cnt
);

    logic [data_w-1:0] next_dout;
    logic [byte_w-1:0] next_tx_data;
    logic              next_tx_valid;
    logic              next_rx_ready;
    logic              next_cnt_clear;
    logic              tdata_wr;

    assign tdata_wr = io_en && (addr == addr_uart_tdata);

    // *************************************************
    // Address decode.
    // *************************************************
    always_comb begin
        next_dout      = '0;
        next_tx_data   = tx_data;
        next_tx_valid  = tx_valid;
        next_rx_ready  = 1'b0;
        next_cnt_clear = 1'b0;

        if (tx_valid && tx_ready) begin
            next_tx_valid = 1'b0;
        end

        if (io_en) begin
            case (addr)
                addr_uart_ctrl: begin
                    next_dout = {{(data_w - 2){1'b0}}, rx_valid, tx_ready};
                end
                addr_uart_rdata: begin
                    next_dout     = {{(data_w - byte_w){1'b0}}, rx_data};
                    next_rx_ready = 1'b1;
                end
                addr_uart_tdata: begin
                    // A new byte replaces one still pending.
                    next_tx_data  = din[byte_w-1:0];
                    next_tx_valid = 1'b1;
                end
                addr_cycle_cnt: begin
                    next_dout = cycle_cnt;
                end
                addr_inst_cnt: begin
                    next_dout = inst_cnt;
                end
                addr_rst_cnt: begin
                    next_cnt_clear = 1'b1;
                end
                addr_br_inst_cnt: begin
                    next_dout = br_inst_cnt;
                end
                addr_br_suc_cnt: begin
                    next_dout = br_suc_cnt;
                end
                default: begin
                    next_dout = '0;
                end
            endcase
        end
    end

    // *************************************************
    // Registers.
    // *************************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dout      <= '0;
            tx_valid  <= 1'b0;
            rx_ready  <= 1'b0;
            cnt_clear <= 1'b0;
        end else begin
            dout      <= next_dout;
            tx_valid  <= next_tx_valid;
            rx_ready  <= next_rx_ready;
            cnt_clear <= next_cnt_clear;
        end
    end

    always_ff @(posedge clk) begin
        tx_data <= next_tx_data;
    end

    // Pending byte holds until the transmitter takes it.
    a_tx_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        (tx_valid && !tx_ready && !tdata_wr) |=> $stable(tx_data)
    ) else $error("mmio_regs: tx_data changed while waiting for tx_ready");

endmodule

`default_nettype wire

// File: logic/perf_counters.sv
`timescale 1ns/10ps
`default_nettype none

module perf_counters import io_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cnt_clear,
    input  logic              inst_retire,
    input  logic              br_inst,
    input  logic              br_suc,
    output logic [data_w-1:0] cycle_cnt,
    output logic [data_w-1:0] inst_cnt,
    output logic [data_w-1:0] br_inst_cnt,
    output logic [data_w-1:0] br_suc_cnt
);

    // Clear wins over any event in the same cycle.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycle_cnt   <= '0;
            inst_cnt    <= '0;
            br_inst_cnt <= '0;
            br_suc_cnt  <= '0;
        end else if (cnt_clear) begin
            cycle_cnt   <= '0;
            inst_cnt    <= '0;
            br_inst_cnt <= '0;
            br_suc_cnt  <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
            if (inst_retire) begin
                inst_cnt <= inst_cnt + 1'b1;
            end
            if (br_inst) begin
                br_inst_cnt <= br_inst_cnt + 1'b1;
            end
            if (br_suc) begin
                br_suc_cnt <= br_suc_cnt + 1'b1;
            end
        end
    end

    // A taken branch must also be a branch.
    a_br_suc: assert property (
        @(posedge clk) disable iff (!arst_n)
        br_suc |-> br_inst
    ) else $error("perf_counters: br_suc without br_inst");

endmodule

`default_nettype wire

// File: logic/uart.sv
`timescale 1ns/10ps
`default_nettype none

module uart import io_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [byte_w-1:0] tx_data,
    input  logic              tx_valid,
    output logic              tx_ready,
    output logic [byte_w-1:0] rx_data,
    output logic              rx_valid,
    input  logic              rx_ready,
    input  logic              serial_in,
    output logic              serial_out
);

    logic [1:0] sync;

    // Two-flop synchronizer, idle high so reset raises no start bit.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync <= 2'b11;
        end else begin
            sync <= {sync[0], serial_in};
        end
    end

    uart_tx u_tx (
        .clk        (clk),
        .arst_n     (arst_n),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .serial_out (serial_out)
    );

    uart_rx u_rx (
        .clk       (clk),
        .arst_n    (arst_n),
        .serial_in (sync[1]),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready)
    );

endmodule

`default_nettype wire

// File: logic/uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx import io_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              serial_in,
    output logic [byte_w-1:0] rx_data,
    output logic              rx_valid,
    input  logic              rx_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_t;

    rx_state_t            state;
    logic [bit_cnt_w-1:0] clk_cnt;
    logic [bit_idx_w-1:0] bit_idx;
    logic [byte_w-1:0]    shreg;
    logic                 bit_end;
    logic                 half_end;
    logic                 accept;

    assign bit_end  = clk_cnt == bit_cnt_w'(clks_per_bit - 1);
    assign half_end = clk_cnt == bit_cnt_w'(clks_per_bit / 2 - 1);

    // Good stop bit and room in the buffer.
    assign accept = (state == st_stop) && bit_end && serial_in && (!rx_valid || rx_ready);

    // *************************************************
    // Frame FSM.
    // *************************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= st_idle;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else begin
            case (state)
                st_idle: begin
                    clk_cnt <= '0;
                    if (!serial_in) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    // Recheck the start bit at half a bit time.
                    if (half_end) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= serial_in ? st_idle : st_data;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        if (bit_idx == bit_idx_w'(byte_w - 1)) begin
                            state <= st_stop;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= st_idle;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_valid <= 1'b0;
        end else if (accept) begin
            rx_valid <= 1'b1;
        end else if (rx_ready) begin
            rx_valid <= 1'b0;
        end
    end

    // Data path, LSB first.
    always_ff @(posedge clk) begin
        if (state == st_data && bit_end) begin
            shreg <= {serial_in, shreg[byte_w-1:1]};
        end
        if (accept) begin
            rx_data <= shreg;
        end
    end

    a_rx_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        (rx_valid && !rx_ready) |=> (rx_valid && $stable(rx_data))
    ) else $error("uart_rx: buffered byte changed before it was taken");

endmodule

`default_nettype wire

// File: logic/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx import io_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [byte_w-1:0] tx_data,
    input  logic              tx_valid,
    output logic              tx_ready,
    output logic              serial_out
);

    logic [frame_bits-1:0] frame;
    logic [bit_cnt_w-1:0]  clk_cnt;
    logic [bit_idx_w-1:0]  bit_idx;
    logic                  busy;

    assign tx_ready = !busy;
    // Line driven straight from the shift register.
    assign serial_out = frame[0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            frame   <= '1;
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else if (!busy) begin
            if (tx_valid) begin
                frame   <= {1'b1, tx_data, 1'b0};
                busy    <= 1'b1;
                clk_cnt <= '0;
                bit_idx <= '0;
            end
        end else if (clk_cnt == bit_cnt_w'(clks_per_bit - 1)) begin
            clk_cnt <= '0;
            frame   <= {1'b1, frame[frame_bits-1:1]};
            // Stop bit done.
            if (bit_idx == bit_idx_w'(frame_bits - 1)) begin
                busy <= 1'b0;
            end else begin
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // Line rests high whenever the transmitter is ready.
    a_tx_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        tx_ready |-> serial_out
    ) else $error("uart_tx: serial_out low while no frame is in progress");

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the I/O block testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module io_tb \
    --Mdir obj_dir -o io_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/io_tb_sim)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx 'All tests passed!'; then
    exit 0
fi
exit 1

// File: testbench/io_tb.sv
`timescale 1ns/10ps
`default_nettype none

module io_tb import io_pkg::*; ;

    logic              clk;
    logic              arst_n;
    logic [data_w-1:0] addr;
    logic [data_w-1:0] din;
    logic              io_en;
    logic              inst_retire;
    logic              br_inst;
    logic              br_suc;
    logic              serial_in;
    logic              serial_out;
    logic [data_w-1:0] dout;

    logic [31:0] rng_state;
    logic [31:0] cyc;
    logic [31:0] last_issue;
    logic [31:0] rst_cyc;
    logic [31:0] exp_inst;
    logic [31:0] exp_br;
    logic [31:0] exp_suc;
    logic [7:0]  tx_q[$];
    logic [7:0]  rx_q[$];
    string       cur_test;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;
    int          checks;

    io_top dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .addr        (addr),
        .din         (din),
        .io_en       (io_en),
        .inst_retire (inst_retire),
        .br_inst     (br_inst),
        .br_suc      (br_suc),
        .serial_in   (serial_in),
        .serial_out  (serial_out),
        .dout        (dout)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Cycle index, stable across each rising edge.
    always @(negedge clk) begin
        cyc <= cyc + 32'd1;
    end

    // **************************************************
    // Helpers.
    // **************************************************
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_value(input string label, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("Error: %s (%s) expected 0x%08h actual 0x%08h", cur_test, label, exp, act);
            test_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout in %s: %s", cur_test, what);
        test_errors++;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        total_errors += test_errors;
        $display("%-10s %s (%0d errors)", cur_test, (test_errors == 0) ? "ok" : "FAILED",
                 test_errors);
        test_errors = 0;
    endtask

    // One-cycle access; returns at the falling edge where dout holds its result.
    task automatic bus_access(input logic [31:0] a, input logic [31:0] d);
        @(posedge clk);
        last_issue = cyc;
        addr  <= a;
        din   <= d;
        io_en <= 1'b1;
        @(posedge clk);
        addr  <= '0;
        din   <= '0;
        io_en <= 1'b0;
        @(negedge clk);
    endtask

    task automatic bus_read(input logic [31:0] a, output logic [31:0] data);
        bus_access(a, next_rand());
        data = dout;
    endtask

    task automatic wait_ctrl_bit(input int bit_pos, input string what);
        logic [31:0] ctrl;
        int          polls;
        polls = 0;
        bus_read(addr_uart_ctrl, ctrl);
        while (ctrl[bit_pos] !== 1'b1 && polls < 200) begin
            bus_read(addr_uart_ctrl, ctrl);
            polls++;
        end
        if (ctrl[bit_pos] !== 1'b1) begin
            report_timeout(what);
        end
    endtask

    // 8N1 frame on serial_in, LSB first.
    task automatic send_serial(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            repeat (clks_per_bit) begin
                @(posedge clk);
                serial_in <= frame[i];
            end
        end
    endtask

    // Samples serial_out at bit centers.
    task automatic decode_serial(output logic [7:0] data, output logic stop_bit);
        int waited;
        waited   = 0;
        data     = '0;
        stop_bit = 1'b0;
        @(negedge clk);
        while (serial_out !== 1'b0 && waited < 4 * clks_per_bit) begin
            @(negedge clk);
            waited++;
        end
        if (serial_out !== 1'b0) begin
            report_timeout("no start bit seen on serial_out");
        end else begin
            repeat (clks_per_bit / 2) @(negedge clk);
            check_value("tx start bit", 32'd0, {31'd0, serial_out});
            for (int i = 0; i < 8; i++) begin
                repeat (clks_per_bit) @(negedge clk);
                data[i] = serial_out;
            end
            repeat (clks_per_bit) @(negedge clk);
            stop_bit = serial_out;
        end
    endtask

    // **************************************************
    // Tests.
    // **************************************************
    initial begin
        logic [31:0] r;
        logic [31:0] v;
        logic [7:0]  b;
        logic        stop;

        rng_state    = 32'd86539;
        cyc          = '0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        checks       = 0;
        arst_n       = 1'b0;
        addr         = '0;
        din          = '0;
        io_en        = 1'b0;
        inst_retire  = 1'b0;
        br_inst      = 1'b0;
        br_suc       = 1'b0;
        serial_in    = 1'b1;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        cur_test = "reset";
        @(negedge clk);
        check_value("serial_out idle", 32'd1, {31'd0, serial_out});
        check_value("dout idle", 32'd0, dout);
        bus_read(addr_uart_ctrl, v);
        check_value("ctrl", 32'd1, v);
        bus_access(addr_rst_cnt, next_rand());
        rst_cyc = last_issue;
        bus_read(addr_cycle_cnt, v);
        check_value("cycle_cnt", last_issue - rst_cyc - 32'd2, v);
        bus_read(addr_inst_cnt, v);
        check_value("inst_cnt", 32'd0, v);
        bus_read(addr_br_inst_cnt, v);
        check_value("br_inst_cnt", 32'd0, v);
        bus_read(addr_br_suc_cnt, v);
        check_value("br_suc_cnt", 32'd0, v);
        end_test();

        cur_test = "counters";
        exp_inst = '0;
        exp_br   = '0;
        exp_suc  = '0;
        bus_access(addr_rst_cnt, next_rand());
        rst_cyc = last_issue;
        for (int i = 0; i < 60; i++) begin
            r = next_rand();
            @(posedge clk);
            inst_retire <= r[0];
            br_inst     <= r[1];
            br_suc      <= r[1] & r[2];
            if (r[0]) exp_inst++;
            if (r[1]) exp_br++;
            if (r[1] && r[2]) exp_suc++;
            @(posedge clk);
            inst_retire <= 1'b0;
            br_inst     <= 1'b0;
            br_suc      <= 1'b0;
            repeat (r[5:4]) @(posedge clk);
        end
        bus_read(addr_inst_cnt, v);
        check_value("inst_cnt", exp_inst, v);
        bus_read(addr_br_inst_cnt, v);
        check_value("br_inst_cnt", exp_br, v);
        bus_read(addr_br_suc_cnt, v);
        check_value("br_suc_cnt", exp_suc, v);
        bus_read(addr_cycle_cnt, v);
        check_value("cycle_cnt", last_issue - rst_cyc - 32'd2, v);
        end_test();

        cur_test = "transmit";
        for (int i = 0; i < 20; i++) begin
            wait_ctrl_bit(0, "tx_ready never set in ctrl");
            r = next_rand();
            tx_q.push_back(r[7:0]);
            bus_access(addr_uart_tdata, r);
            decode_serial(b, stop);
            check_value("tx byte", {24'd0, tx_q.pop_front()}, {24'd0, b});
            check_value("tx stop bit", 32'd1, {31'd0, stop});
        end
        end_test();

        cur_test = "receive";
        for (int i = 0; i < 20; i++) begin
            r = next_rand();
            rx_q.push_back(r[7:0]);
            repeat (r[10:8]) @(posedge clk);
            send_serial(r[7:0]);
            wait_ctrl_bit(1, "rx_valid never set in ctrl");
            bus_read(addr_uart_rdata, v);
            check_value("rx byte", {24'd0, rx_q.pop_front()}, v);
            bus_read(addr_uart_ctrl, v);
            check_value("ctrl after read", 32'd1, v);
        end
        end_test();

        cur_test = "decode";
        for (int i = 0; i < 20; i++) begin
            r = next_rand();
            // Move out of the register window.
            if (r >= 32'h8000_0000 && r <= 32'h8000_0020) begin
                r = r ^ 32'h4000_0000;
            end
            bus_read(r, v);
            check_value("unmapped read", 32'd0, v);
            bus_read(addr_cycle_cnt, v);
            @(negedge clk);
            check_value("dout after read", 32'd0, dout);
        end
        bus_access(addr_rst_cnt, next_rand());
        check_value("dout after rst_cnt", 32'd0, dout);
        repeat (5) begin
            @(negedge clk);
            check_value("dout idle", 32'd0, dout);
        end
        end_test();

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors", tests_run,
                 tests_failed, checks, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
